//--- project.f
hw/fpu_pkg.sv
hw/fp_unpack.sv
hw/fp_special.sv
hw/fp_add_core.sv
hw/fp_mul_core.sv
hw/fp_round_pack.sv
hw/fpu_top.sv
dv/fpu_tb.sv

//--- dv/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int N_ADD      = 200;
    localparam int N_NEAR     = 40;
    localparam int N_MUL      = 200;
    localparam int N_MUL_WIDE = 100;
    localparam int N_EDGE     = 16;   // Upper bound of the edge table
    localparam int N_SPECIAL  = 24;
    localparam int N_BURST    = 64;
    localparam int N_STALL    = 200;
    localparam int N_TESTS    = 1 + N_ADD + N_NEAR + N_MUL + N_MUL_WIDE + N_EDGE
                                + N_SPECIAL + N_BURST + N_STALL;
    localparam int WATCHDOG_CYCLES = N_TESTS * 40 + RST_CYCLES;

    typedef struct packed {
        fpu_pkg::fp32_t  res;
        fpu_pkg::flags_t flg;
    } outcome_t;

    typedef struct packed {
        fpu_pkg::fp32_t a;
        fpu_pkg::fp32_t b;
        logic [1:0]     op;
        outcome_t       want;
    } entry_t;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    fpu_pkg::fp32_t  op_a;
    fpu_pkg::fp32_t  op_b;
    fpu_pkg::op_t    op;
    logic            out_valid;
    logic            out_ready;
    fpu_pkg::fp32_t  result;
    fpu_pkg::flags_t flags;

    entry_t exp_q[$];             // Expected results in acceptance order
    int     sent_count        = 0;
    int     recv_count        = 0;
    int     cycle_cnt         = 0;
    int     last_accept_cycle = 0;
    int     last_out_cycle    = 0;
    logic   stall_mode        = 1'b0;
    logic   ready_pattern [0:255];

    // Output seen on the previous edge while the sink was not ready
    logic            held_valid = 1'b0;
    fpu_pkg::fp32_t  held_result;
    fpu_pkg::flags_t held_flags;

    fpu_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op_a      (op_a),
        .op_b      (op_b),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .flags     (flags)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_result(input string name, input fpu_pkg::fp32_t got,
                                input fpu_pkg::fp32_t want, input string ctx);
        if (got !== want) begin
            report_failure($sformatf("Fail %s: got %08h, expected %08h (%s)",
                                     name, got, want, ctx));
        end
    endtask

    task automatic check_flags(input string name, input fpu_pkg::flags_t got,
                               input fpu_pkg::flags_t want, input string ctx);
        if (got !== want) begin
            report_failure($sformatf("Fail %s: got %h, expected %h (%s)",
                                     name, got, want, ctx));
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_failure($sformatf("Fail %s: got %h, expected %h", name, got, want));
        end
    endtask

    function automatic real pow2(input int k);
        real r;
        r = 1.0;
        for (int i = 0; i < k; i++) r = r * 2.0;
        for (int i = 0; i < -k; i++) r = r / 2.0;
        return r;
    endfunction

    // Exact value of a normal binary32 operand
    function automatic real exact_value(input fpu_pkg::fp32_t x);
        real m;
        m = {1'b1, x[22:0]};
        m = m * pow2(int'(x[30:23]) - 150);
        return x[31] ? -m : m;
    endfunction

    function automatic fpu_pkg::fp_class_t operand_class(input fpu_pkg::fp32_t x);
        if (x[30:23] == 8'h00) return fpu_pkg::CLS_ZERO;   // Subnormals count as zero
        if (x[30:23] != 8'hFF) return fpu_pkg::CLS_NORMAL;
        return (x[22:0] == '0) ? fpu_pkg::CLS_INF : fpu_pkg::CLS_NAN;
    endfunction

    // Nearest-even conversion of an exact real to binary32, no subnormals
    function automatic outcome_t round_to_binary32(input real x);
        outcome_t    o;
        logic        s;
        real         m;
        real         fl;
        real         rem;
        int          e;
        int          biased;
        logic [24:0] mant;
        o = '0;
        if (x != 0.0) begin
            s = (x < 0.0);
            m = s ? -x : x;
            e = 0;
            while (m >= 2.0) begin
                m = m / 2.0;
                e++;
            end
            while (m < 1.0) begin
                m = m * 2.0;
                e--;
            end
            m    = m * 8388608.0;   // 24 integer bits
            fl   = $floor(m);
            rem  = m - fl;
            mant = $rtoi(fl);
            if (rem > 0.5 || (rem == 0.5 && mant[0])) mant = mant + 25'd1;
            o.flg[fpu_pkg::FLAG_INEXACT] = (rem != 0.0);
            if (mant == 25'h100_0000) begin
                mant = 25'h080_0000;
                e++;
            end
            biased = e + 127;
            if (biased > 254) begin
                o.res = {s, 8'hFF, 23'h0};
                o.flg[fpu_pkg::FLAG_OVERFLOW] = 1'b1;
                o.flg[fpu_pkg::FLAG_INEXACT]  = 1'b1;
            end else if (biased < 1) begin
                o.res = {s, 31'h0};
                o.flg[fpu_pkg::FLAG_UNDERFLOW] = 1'b1;
                o.flg[fpu_pkg::FLAG_INEXACT]   = 1'b1;
            end else begin
                o.res = {s, 8'(biased), mant[22:0]};
            end
        end
        return o;
    endfunction

    function automatic outcome_t ref_fpu(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                                         input fpu_pkg::op_t o);
        outcome_t           r;
        fpu_pkg::fp_class_t ca;
        fpu_pkg::fp_class_t cb;
        logic               eb;
        ca = operand_class(a);
        cb = operand_class(b);
        eb = b[31] ^ (o == fpu_pkg::OP_SUB);   // Sign of b after the operation
        r  = '0;
        if (o == fpu_pkg::OP_RSVD || ca == fpu_pkg::CLS_NAN || cb == fpu_pkg::CLS_NAN) begin
            r.res = fpu_pkg::QNAN;
            r.flg[fpu_pkg::FLAG_INVALID] = 1'b1;
        end else if (o != fpu_pkg::OP_MUL) begin
            if (ca == fpu_pkg::CLS_INF && cb == fpu_pkg::CLS_INF && a[31] != eb) begin
                r.res = fpu_pkg::QNAN;
                r.flg[fpu_pkg::FLAG_INVALID] = 1'b1;
            end else if (ca == fpu_pkg::CLS_INF) begin
                r.res = {a[31], 8'hFF, 23'h0};
            end else if (cb == fpu_pkg::CLS_INF) begin
                r.res = {eb, 8'hFF, 23'h0};
            end else if (ca == fpu_pkg::CLS_ZERO && cb == fpu_pkg::CLS_ZERO) begin
                r.res = {a[31] & eb, 31'h0};
            end else if (ca == fpu_pkg::CLS_ZERO) begin
                r.res = {eb, b[30:0]};
            end else if (cb == fpu_pkg::CLS_ZERO) begin
                r.res = a;
            end else begin
                r = round_to_binary32(exact_value(a) + (eb ? -1.0 : 1.0) *
                                      exact_value({1'b0, b[30:0]}));
            end
        end else begin
            if ((ca == fpu_pkg::CLS_INF && cb == fpu_pkg::CLS_ZERO) ||
                (cb == fpu_pkg::CLS_INF && ca == fpu_pkg::CLS_ZERO)) begin
                r.res = fpu_pkg::QNAN;
                r.flg[fpu_pkg::FLAG_INVALID] = 1'b1;
            end else if (ca == fpu_pkg::CLS_INF || cb == fpu_pkg::CLS_INF) begin
                r.res = {a[31] ^ b[31], 8'hFF, 23'h0};
            end else if (ca == fpu_pkg::CLS_ZERO || cb == fpu_pkg::CLS_ZERO) begin
                r.res = {a[31] ^ b[31], 31'h0};
            end else begin
                r = round_to_binary32(exact_value(a) * exact_value(b));
            end
        end
        return r;
    endfunction

    // Scoreboard, output side popped before the input side is pushed
    always @(posedge clk) begin
        entry_t e;
        string  ctx;
        cycle_cnt = cycle_cnt + 1;
        if (!rst && held_valid) begin
            expect_level("out_valid", out_valid, 1'b1);
            check_result("result", result, held_result, "held during stall");
            check_flags("flags", flags, held_flags, "held during stall");
        end
        if (!rst && out_valid && !out_ready) begin
            expect_level("in_ready", in_ready, 1'b0);   // Whole pipe frozen
        end
        held_valid  = !rst && out_valid && !out_ready;
        held_result = result;
        held_flags  = flags;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("A result came out with no operation outstanding");
            end else begin
                e   = exp_q.pop_front();
                ctx = $sformatf("op %0d, a %08h, b %08h", e.op, e.a, e.b);
                check_result("result", result, e.want.res, ctx);
                check_flags("flags", flags, e.want.flg, ctx);
                recv_count     = recv_count + 1;
                last_out_cycle = cycle_cnt;
            end
        end
        if (!rst && in_valid && in_ready) begin
            e.a    = op_a;
            e.b    = op_b;
            e.op   = op;
            e.want = ref_fpu(op_a, op_b, op);
            exp_q.push_back(e);
            sent_count        = sent_count + 1;
            last_accept_cycle = cycle_cnt;
        end
    end

    always @(negedge clk) begin
        out_ready = stall_mode ? ready_pattern[cycle_cnt % 256] : 1'b1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the run finished");
    end

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_op(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                           input fpu_pkg::op_t o);
        int n0;
        n0       = sent_count;
        in_valid = 1'b1;
        op_a     = a;
        op_b     = b;
        op       = o;
        while (sent_count == n0) @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain;
        in_valid = 1'b0;
        while (recv_count != sent_count) @(negedge clk);
    endtask

    function automatic fpu_pkg::fp32_t rand_fp(input int e_lo, input int e_hi);
        return {1'($urandom_range(1, 0)), 8'($urandom_range(e_hi, e_lo)), 23'($urandom)};
    endfunction

    function automatic fpu_pkg::op_t rand_op();
        case ($urandom_range(2, 0))
            0:       return fpu_pkg::OP_ADD;
            1:       return fpu_pkg::OP_SUB;
            default: return fpu_pkg::OP_MUL;
        endcase
    endfunction

    initial begin
        fpu_pkg::fp32_t a;
        fpu_pkg::fp32_t b;
        int             eb;
        int             d;
        int             first_cycle;
        void'($urandom(24035));
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        op_a      = '0;
        op_b      = '0;
        op        = fpu_pkg::OP_ADD;
        out_ready = 1'b1;
        for (int i = 0; i < 256; i++) ready_pattern[i] = ($urandom_range(2, 0) != 0);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        expect_level("out_valid", out_valid, 1'b0);
        expect_level("in_ready", in_ready, 1'b1);
        check_result("result", result, '0, "after reset");
        check_flags("flags", flags, '0, "after reset");

        // Single operation, result leaves three edges after the accepting edge
        send_op(32'h3F80_0000, 32'h4000_0000, fpu_pkg::OP_ADD);
        drain();
        if (last_out_cycle - last_accept_cycle != fpu_pkg::PIPE_DEPTH) begin
            report_failure($sformatf("Latency was %0d cycles instead of %0d",
                                     last_out_cycle - last_accept_cycle,
                                     fpu_pkg::PIPE_DEPTH));
        end

        // Add and subtract with exponent gaps up to 28
        for (int i = 0; i < N_ADD; i++) begin
            a  = rand_fp(1, 254);
            eb = int'(a[30:23]) + int'($urandom_range(56, 0)) - 28;
            if (eb < 1) eb = 1;
            if (eb > 254) eb = 254;
            b = {1'($urandom_range(1, 0)), 8'(eb), 23'($urandom)};
            send_op(a, b, ($urandom_range(1, 0) == 1) ? fpu_pkg::OP_SUB : fpu_pkg::OP_ADD);
        end

        // Near and exact cancellation
        for (int i = 0; i < N_NEAR; i++) begin
            a = rand_fp(2, 253);
            d = (i % 4 == 0) ? 0 : int'($urandom_range(16, 0)) - 8;
            b = a + 32'(d);
            if (i % 2 == 0) begin
                send_op(a, b, fpu_pkg::OP_SUB);
            end else begin
                send_op(a, {~b[31], b[30:0]}, fpu_pkg::OP_ADD);
            end
        end

        for (int i = 0; i < N_MUL; i++) begin
            send_op(rand_fp(64, 190), rand_fp(64, 190), fpu_pkg::OP_MUL);
        end
        for (int i = 0; i < N_MUL_WIDE; i++) begin
            send_op(rand_fp(1, 254), rand_fp(1, 254), fpu_pkg::OP_MUL);   // Hits both range ends
        end

        // Overflow, underflow and rounding edges
        send_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, fpu_pkg::OP_ADD);
        send_op(32'hFF7F_FFFF, 32'h7F7F_FFFF, fpu_pkg::OP_SUB);
        send_op(32'h7F7F_FFFF, 32'h7300_0000, fpu_pkg::OP_ADD);   // Tie rounds up past max
        send_op(32'h7F7F_FFFF, 32'h7280_0000, fpu_pkg::OP_ADD);
        send_op(32'h7F00_0000, 32'h4000_0000, fpu_pkg::OP_MUL);
        send_op(32'h7F00_0000, 32'hC040_0000, fpu_pkg::OP_MUL);
        send_op(32'h5F80_0000, 32'h5F80_0000, fpu_pkg::OP_MUL);
        send_op(32'h1F80_0000, 32'h1F80_0000, fpu_pkg::OP_MUL);
        send_op(32'h9F80_0000, 32'h1F80_0000, fpu_pkg::OP_MUL);
        send_op(32'h0080_0000, 32'h3F00_0000, fpu_pkg::OP_MUL);
        send_op(32'h8080_0000, 32'h3F7F_FFFF, fpu_pkg::OP_MUL);
        send_op(32'h0080_0000, 32'h3F80_0001, fpu_pkg::OP_MUL);
        send_op(32'h0080_0001, 32'h0080_0000, fpu_pkg::OP_SUB);
        send_op(32'h3F80_0000, 32'h3080_0000, fpu_pkg::OP_ADD);
        send_op(32'h3F80_0000, 32'h3080_0000, fpu_pkg::OP_SUB);

        // Special operands
        send_op(32'h7FC0_0000, 32'h3F80_0000, fpu_pkg::OP_ADD);
        send_op(32'h3F80_0000, 32'h7F80_0001, fpu_pkg::OP_MUL);
        send_op(32'hFFC0_0001, 32'h7F80_0000, fpu_pkg::OP_SUB);
        send_op(32'h7F80_0000, 32'hFF80_0000, fpu_pkg::OP_ADD);
        send_op(32'h7F80_0000, 32'h7F80_0000, fpu_pkg::OP_SUB);
        send_op(32'h7F80_0000, 32'h7F80_0000, fpu_pkg::OP_ADD);
        send_op(32'hFF80_0000, 32'h7F80_0000, fpu_pkg::OP_SUB);
        send_op(32'h3F80_0000, 32'h7F80_0000, fpu_pkg::OP_SUB);
        send_op(32'hC000_0000, 32'hFF80_0000, fpu_pkg::OP_ADD);
        send_op(32'h7F80_0000, 32'h0000_0000, fpu_pkg::OP_MUL);
        send_op(32'h8000_0000, 32'hFF80_0000, fpu_pkg::OP_MUL);
        send_op(32'hFF80_0000, 32'h4000_0000, fpu_pkg::OP_MUL);
        send_op(32'hFF80_0000, 32'hC040_0000, fpu_pkg::OP_MUL);
        send_op(32'h0000_0000, 32'h8000_0000, fpu_pkg::OP_ADD);
        send_op(32'h8000_0000, 32'h8000_0000, fpu_pkg::OP_ADD);
        send_op(32'h8000_0000, 32'h0000_0000, fpu_pkg::OP_SUB);
        send_op(32'h0000_0000, 32'h0000_0000, fpu_pkg::OP_SUB);
        send_op(32'h0000_0001, 32'h3FC0_0000, fpu_pkg::OP_ADD);   // Subnormal reads as zero
        send_op(32'h8040_0000, 32'h4000_0000, fpu_pkg::OP_MUL);
        send_op(32'h0040_0000, 32'h0040_0000, fpu_pkg::OP_ADD);
        send_op(32'h4000_0000, 32'h8000_0001, fpu_pkg::OP_SUB);
        send_op(32'h3F80_0000, 32'h3F80_0000, fpu_pkg::OP_RSVD);
        send_op(32'h7FC0_0000, 32'h0000_0000, fpu_pkg::OP_RSVD);
        send_op(32'h0000_0000, 32'h40A0_0000, fpu_pkg::OP_MUL);
        drain();

        // Burst with out_ready high, one acceptance per cycle
        send_op(rand_fp(110, 135), rand_fp(110, 135), rand_op());
        first_cycle = last_accept_cycle;
        for (int i = 1; i < N_BURST; i++) begin
            send_op(rand_fp(110, 135), rand_fp(110, 135), rand_op());
        end
        if (last_accept_cycle - first_cycle != N_BURST - 1) begin
            report_failure($sformatf("Burst of %0d operations took %0d cycles to accept",
                                     N_BURST, last_accept_cycle - first_cycle + 1));
        end
        drain();

        // Random output stalls and input gaps
        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            send_op(rand_fp(110, 135), rand_fp(110, 135), rand_op());
            if ($urandom_range(3, 0) == 0) idle_cycles(1);
        end
        drain();
        stall_mode = 1'b0;
        idle_cycles(4);

        if (exp_q.size() == 0 && recv_count == sent_count) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure("Operations were still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- hw/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  fpu_pkg::fp32_t  op_a,
    input  fpu_pkg::fp32_t  op_b,
    input  fpu_pkg::op_t    op,
    output logic            out_valid,
    input  logic            out_ready,
    output fpu_pkg::fp32_t  result,
    output fpu_pkg::flags_t flags
);

    localparam int LAST = fpu_pkg::PIPE_DEPTH - 1;

    logic [fpu_pkg::PIPE_DEPTH-1:0] vld;   // One valid bit per stage
    logic                           advance;

    fpu_pkg::fp32_t     s1_a, s1_b;
    fpu_pkg::op_t       s1_op;

    logic               sign_a, sign_b;
    fpu_pkg::exp_t      exp_a, exp_b;
    fpu_pkg::sig_t      sig_a, sig_b;
    fpu_pkg::fp_class_t cls_a, cls_b;

    logic               special;
    fpu_pkg::fp32_t     special_result;
    fpu_pkg::flags_t    special_flags;

    logic               add_sign, add_zero;
    fpu_pkg::exp_ext_t  add_exp;
    fpu_pkg::ext_sig_t  add_sig;
    logic               mul_sign;
    fpu_pkg::exp_ext_t  mul_exp;
    fpu_pkg::ext_sig_t  mul_sig;

    logic               s2_special;
    fpu_pkg::fp32_t     s2_special_result;
    fpu_pkg::flags_t    s2_special_flags;
    fpu_pkg::op_t       s2_op;
    logic               s2_sign;
    fpu_pkg::exp_ext_t  s2_exp;
    fpu_pkg::ext_sig_t  s2_sig;
    logic               s2_sum_zero;
    logic               s2_cancel;

    fpu_pkg::fp32_t     rp_result;
    fpu_pkg::flags_t    rp_flags;

    // Whole pipe moves unless a finished result is waiting
    assign advance   = !vld[LAST] || out_ready;
    assign in_ready  = advance;
    assign out_valid = vld[LAST];

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (advance) begin
            vld <= {vld[LAST-1:0], in_valid};
        end
    end

    // Stage 1, raw operands
    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            s1_a  <= op_a;
            s1_b  <= op_b;
            s1_op <= op;
        end
    end

    fp_unpack u_unpack (
        .op_a   (s1_a),
        .op_b   (s1_b),
        .sign_a (sign_a),
        .sign_b (sign_b),
        .exp_a  (exp_a),
        .exp_b  (exp_b),
        .sig_a  (sig_a),
        .sig_b  (sig_b),
        .cls_a  (cls_a),
        .cls_b  (cls_b)
    );

    fp_special u_special (
        .op             (s1_op),
        .sign_a         (sign_a),
        .sign_b         (sign_b),
        .cls_a          (cls_a),
        .cls_b          (cls_b),
        .op_a           (s1_a),
        .op_b           (s1_b),
        .special        (special),
        .special_result (special_result),
        .special_flags  (special_flags)
    );

    fp_add_core u_add (
        .sub      (s1_op == fpu_pkg::OP_SUB),
        .sign_a   (sign_a),
        .sign_b   (sign_b),
        .exp_a    (exp_a),
        .exp_b    (exp_b),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .sum_sign (add_sign),
        .sum_exp  (add_exp),
        .sum_sig  (add_sig),
        .sum_zero (add_zero)
    );

    fp_mul_core u_mul (
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .exp_a     (exp_a),
        .exp_b     (exp_b),
        .sig_a     (sig_a),
        .sig_b     (sig_b),
        .prod_sign (mul_sign),
        .prod_exp  (mul_exp),
        .prod_sig  (mul_sig)
    );

    // Stage 2, special decision and the unrounded core result
    always_ff @(posedge clk) begin
        if (advance && vld[0]) begin
            s2_special        <= special;
            s2_special_result <= special_result;
            s2_special_flags  <= special_flags;
            s2_op             <= s1_op;
            s2_sum_zero       <= add_zero;
            if (s1_op == fpu_pkg::OP_MUL) begin
                s2_sign <= mul_sign;
                s2_exp  <= mul_exp;
                s2_sig  <= mul_sig;
            end else begin
                s2_sign <= add_sign;
                s2_exp  <= add_exp;
                s2_sig  <= add_sig;
            end
        end
    end

    fp_round_pack u_round (
        .sign   (s2_sign),
        .exp    (s2_exp),
        .sig    (s2_sig),
        .result (rp_result),
        .flags  (rp_flags)
    );

    // Exact cancellation gives +0
    assign s2_cancel = s2_sum_zero &&
                       (s2_op == fpu_pkg::OP_ADD || s2_op == fpu_pkg::OP_SUB);

    // Stage 3, output register
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            flags  <= '0;
        end else if (advance && vld[LAST-1]) begin
            if (s2_special) begin
                result <= s2_special_result;
                flags  <= s2_special_flags;
            end else if (s2_cancel) begin
                result <= '0;
                flags  <= '0;
            end else begin
                result <= rp_result;
                flags  <= rp_flags;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack (
    input  logic                sign,
    input  fpu_pkg::exp_ext_t   exp,
    input  fpu_pkg::ext_sig_t   sig,
    output fpu_pkg::fp32_t      result,
    output fpu_pkg::flags_t     flags
);

    logic              lsb;
    logic              guard;
    logic              round_bit;
    logic              sticky;
    logic              round_up;
    logic [24:0]       sig_rnd;   // Carry out in bit 24
    fpu_pkg::exp_ext_t exp_rnd;
    fpu_pkg::mant_t    frac;

    assign lsb       = sig[3];
    assign guard     = sig[2];
    assign round_bit = sig[1];
    assign sticky    = sig[0];

    // Nearest-even, ties go to an even LSB
    assign round_up = guard & (round_bit | sticky | lsb);
    assign sig_rnd  = {1'b0, sig[26:3]} + {24'b0, round_up};

    // On carry the fraction bits are all zero anyway
    assign exp_rnd = sig_rnd[24] ? (exp + 10'sd1) : exp;
    assign frac    = sig_rnd[22:0];

    always_comb begin
        flags                        = '0;
        flags[fpu_pkg::FLAG_INEXACT] = |sig[2:0];
        if (exp_rnd > fpu_pkg::EXP_MAX_NORM) begin
            result = {sign, fpu_pkg::EXP_ALL_ONES, {fpu_pkg::MANT_WIDTH{1'b0}}};
            flags[fpu_pkg::FLAG_OVERFLOW] = 1'b1;
            flags[fpu_pkg::FLAG_INEXACT]  = 1'b1;
        end else if (exp_rnd < 10'sd1) begin
            result = {sign, 31'b0};   // Flush to signed zero
            flags[fpu_pkg::FLAG_UNDERFLOW] = 1'b1;
            flags[fpu_pkg::FLAG_INEXACT]   = 1'b1;
        end else begin
            result = {sign, exp_rnd[7:0], frac};
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_mul_core.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul_core (
    input  logic                sign_a,
    input  logic                sign_b,
    input  fpu_pkg::exp_t       exp_a,
    input  fpu_pkg::exp_t       exp_b,
    input  fpu_pkg::sig_t       sig_a,
    input  fpu_pkg::sig_t       sig_b,
    output logic                prod_sign,
    output fpu_pkg::exp_ext_t   prod_exp,
    output fpu_pkg::ext_sig_t   prod_sig
);

    logic [47:0]       prod;
    fpu_pkg::exp_ext_t exp_sum;

    assign prod      = sig_a * sig_b;   // Product lies in [1, 4)
    assign prod_sign = sign_a ^ sign_b;

    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - fpu_pkg::EXP_BIAS;

    always_comb begin
        if (prod[47]) begin
            // Product at least two, move the point by one
            prod_sig = {prod[47:22], |prod[21:0]};
            prod_exp = exp_sum + 10'sd1;
        end else begin
            prod_sig = {prod[46:21], |prod[20:0]};
            prod_exp = exp_sum;
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_add_core.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_core (
    input  logic                sub,
    input  logic                sign_a,
    input  logic                sign_b,
    input  fpu_pkg::exp_t       exp_a,
    input  fpu_pkg::exp_t       exp_b,
    input  fpu_pkg::sig_t       sig_a,
    input  fpu_pkg::sig_t       sig_b,
    output logic                sum_sign,
    output fpu_pkg::exp_ext_t   sum_exp,
    output fpu_pkg::ext_sig_t   sum_sig,
    output logic                sum_zero
);

    logic              eff_sign_b;
    logic              a_big;
    logic              eff_sub;
    logic              sign_big, sign_small;
    fpu_pkg::exp_t     exp_big, exp_small;
    fpu_pkg::sig_t     sig_big, sig_small;
    fpu_pkg::exp_ext_t exp_big_x;
    logic [7:0]        exp_diff;
    logic [4:0]        shamt;
    logic [49:0]       small_wide;
    fpu_pkg::ext_sig_t big_ext;
    fpu_pkg::ext_sig_t aligned;
    logic [27:0]       raw_sum;   // One extra bit for the carry
    logic [4:0]        lz;

    assign eff_sign_b = sign_b ^ sub;

    // Larger magnitude goes first
    assign a_big      = ({exp_a, sig_a} >= {exp_b, sig_b});
    assign sign_big   = a_big ? sign_a : eff_sign_b;
    assign sign_small = a_big ? eff_sign_b : sign_a;
    assign exp_big    = a_big ? exp_a : exp_b;
    assign exp_small  = a_big ? exp_b : exp_a;
    assign sig_big    = a_big ? sig_a : sig_b;
    assign sig_small  = a_big ? sig_b : sig_a;

    assign exp_diff = exp_big - exp_small;
    // Past 27 places the whole operand already sits in sticky
    assign shamt = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];

    assign small_wide = {sig_small, 26'b0} >> shamt;
    assign aligned    = {small_wide[49:24], |small_wide[23:0]};
    assign big_ext    = {sig_big, 3'b000};

    assign eff_sub = sign_big ^ sign_small;
    assign raw_sum = eff_sub ? ({1'b0, big_ext} - {1'b0, aligned})
                             : ({1'b0, big_ext} + {1'b0, aligned});

    // Leading zero count below the carry bit
    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < 27; i++) begin
            if (raw_sum[i]) begin
                lz = 5'(26 - i);   // Highest set bit wins
            end
        end
    end

    assign exp_big_x = $signed({2'b00, exp_big});

    always_comb begin
        if (raw_sum[27]) begin
            sum_sig = {raw_sum[27:2], raw_sum[1] | raw_sum[0]};
            sum_exp = exp_big_x + 10'sd1;
        end else begin
            sum_sig = raw_sum[26:0] << lz;   // Cancellation
            sum_exp = exp_big_x - $signed({5'b00000, lz});
        end
    end

    assign sum_sign = sign_big;
    assign sum_zero = (raw_sum == '0);

endmodule

`default_nettype wire

//--- hw/fp_special.sv
`timescale 1ns/1ps
`default_nettype none

module fp_special (
    input  fpu_pkg::op_t       op,
    input  logic               sign_a,
    input  logic               sign_b,
    input  fpu_pkg::fp_class_t cls_a,
    input  fpu_pkg::fp_class_t cls_b,
    input  fpu_pkg::fp32_t     op_a,
    input  fpu_pkg::fp32_t     op_b,
    output logic               special,
    output fpu_pkg::fp32_t     special_result,
    output fpu_pkg::flags_t    special_flags
);

    logic eff_sign_b;   // Sign of b as seen by the adder
    logic a_inf, b_inf, a_zero, b_zero;

    function automatic fpu_pkg::fp32_t make_inf(input logic s);
        make_inf = {s, fpu_pkg::EXP_ALL_ONES, {fpu_pkg::MANT_WIDTH{1'b0}}};
    endfunction

    assign eff_sign_b = sign_b ^ (op == fpu_pkg::OP_SUB);
    assign a_inf      = (cls_a == fpu_pkg::CLS_INF);
    assign b_inf      = (cls_b == fpu_pkg::CLS_INF);
    assign a_zero     = (cls_a == fpu_pkg::CLS_ZERO);
    assign b_zero     = (cls_b == fpu_pkg::CLS_ZERO);

    always_comb begin
        special        = 1'b1;
        special_result = fpu_pkg::QNAN;
        special_flags  = '0;
        if (op == fpu_pkg::OP_RSVD || cls_a == fpu_pkg::CLS_NAN ||
            cls_b == fpu_pkg::CLS_NAN) begin
            special_flags[fpu_pkg::FLAG_INVALID] = 1'b1;
        end else if (op != fpu_pkg::OP_MUL) begin
            if (a_inf && b_inf) begin
                if (sign_a != eff_sign_b) begin
                    special_flags[fpu_pkg::FLAG_INVALID] = 1'b1;  // Inf - Inf
                end else begin
                    special_result = make_inf(sign_a);
                end
            end else if (a_inf) begin
                special_result = make_inf(sign_a);
            end else if (b_inf) begin
                special_result = make_inf(eff_sign_b);
            end else if (a_zero && b_zero) begin
                // Only -0 + -0 stays negative under nearest-even
                special_result = {sign_a & eff_sign_b, 31'b0};
            end else if (a_zero) begin
                special_result = {eff_sign_b, op_b[30:0]};
            end else if (b_zero) begin
                special_result = op_a;
            end else begin
                special = 1'b0;
            end
        end else begin
            if ((a_inf && b_zero) || (b_inf && a_zero)) begin
                special_flags[fpu_pkg::FLAG_INVALID] = 1'b1;
            end else if (a_inf || b_inf) begin
                special_result = make_inf(sign_a ^ sign_b);
            end else if (a_zero || b_zero) begin
                special_result = {sign_a ^ sign_b, 31'b0};
            end else begin
                special = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  fpu_pkg::fp32_t     op_a,
    input  fpu_pkg::fp32_t     op_b,
    output logic               sign_a,
    output logic               sign_b,
    output fpu_pkg::exp_t      exp_a,
    output fpu_pkg::exp_t      exp_b,
    output fpu_pkg::sig_t      sig_a,
    output fpu_pkg::sig_t      sig_b,
    output fpu_pkg::fp_class_t cls_a,
    output fpu_pkg::fp_class_t cls_b
);

    fpu_pkg::mant_t frac_a;
    fpu_pkg::mant_t frac_b;

    function automatic fpu_pkg::fp_class_t classify(input fpu_pkg::exp_t e,
                                                    input fpu_pkg::mant_t f);
        if (e == '0) begin
            classify = fpu_pkg::CLS_ZERO;   // Subnormals flushed here
        end else if (e == fpu_pkg::EXP_ALL_ONES) begin
            classify = (f == '0) ? fpu_pkg::CLS_INF : fpu_pkg::CLS_NAN;
        end else begin
            classify = fpu_pkg::CLS_NORMAL;
        end
    endfunction

    assign sign_a = op_a[31];
    assign exp_a  = op_a[30:23];
    assign frac_a = op_a[22:0];

    assign sign_b = op_b[31];
    assign exp_b  = op_b[30:23];
    assign frac_b = op_b[22:0];

    // Hidden bit only for a nonzero exponent
    assign sig_a = (exp_a == '0) ? '0 : {1'b1, frac_a};
    assign sig_b = (exp_b == '0) ? '0 : {1'b1, frac_b};

    assign cls_a = classify(exp_a, frac_a);
    assign cls_b = classify(exp_b, frac_b);

endmodule

`default_nettype wire

//--- hw/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    // Field widths of the binary32 format
    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 23;
    localparam int SIG_WIDTH  = 24;   // Hidden bit included
    localparam int EXT_WIDTH  = 27;   // Plus guard, round and sticky
    localparam int EXPX_WIDTH = 10;   // Room for under and overflow
    localparam int FLAG_WIDTH = 4;

    localparam int PIPE_DEPTH = 3;

    typedef logic        [FP_WIDTH-1:0]   fp32_t;
    typedef logic        [EXP_WIDTH-1:0]  exp_t;
    typedef logic        [MANT_WIDTH-1:0] mant_t;
    typedef logic        [SIG_WIDTH-1:0]  sig_t;
    typedef logic        [EXT_WIDTH-1:0]  ext_sig_t;
    typedef logic signed [EXPX_WIDTH-1:0] exp_ext_t;
    typedef logic        [FLAG_WIDTH-1:0] flags_t;

    // Flag bit positions
    localparam int FLAG_INVALID   = 3;
    localparam int FLAG_OVERFLOW  = 2;
    localparam int FLAG_UNDERFLOW = 1;
    localparam int FLAG_INEXACT   = 0;

    localparam exp_ext_t EXP_BIAS     = 10'sd127;
    localparam exp_ext_t EXP_MAX_NORM = 10'sd254;  // Largest finite biased exponent
    localparam exp_t     EXP_ALL_ONES = 8'hFF;
    localparam fp32_t    QNAN         = 32'h7FC0_0000;

    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MUL  = 2'd2,
        OP_RSVD = 2'd3   // Reserved, gives NaN
    } op_t;

    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fp_class_t;

endpackage

`default_nettype wire
